/* build.f */
rtl/router_pkg.sv
rtl/ahb_addr_decode.sv
rtl/target_arbiter.sv
rtl/target_port.sv
rtl/response_mux.sv
rtl/ahb_router.sv
tb/ahb_router_chk.sv
tb/ahb_router_tb.sv

/* tb/router_cases.txt */
# imem: valid write size addr wdata exp_rdata latency, then the same seven for dmem
# hex fields except latency, which is decimal, latency 0 means unchecked
1 1 2 00000010 11223344 0 2 1 1 2 00004020 a5a5a5a5 0 2
1 0 2 00000010 0 11223344 1 1 0 2 00004020 0 a5a5a5a5 1
0 0 2 00000000 0 0 0 1 1 0 00004021 00007700 0 2
0 0 2 00000000 0 0 0 1 1 1 00004022 beef0000 0 2
1 0 2 00004020 0 beef77a5 1 0 0 2 00000000 0 0 0
1 0 2 00000010 0 11223344 1 1 1 2 00008004 cafef00d 0 2
1 0 2 00008004 0 cafef00d 2 1 0 2 0000c004 0 cafef00d 1
1 0 2 00008004 0 cafef00d 1 1 0 2 0000c004 0 cafef00d 2
1 0 2 00004020 0 beef77a5 2 1 0 2 00004020 0 beef77a5 1
1 0 2 00000010 0 11223344 1 1 0 2 00000010 0 11223344 2
1 0 2 00000010 0 11223344 2 1 0 2 00000010 0 11223344 1
1 1 2 00000014 0badf00d 0 2 1 0 2 00000014 0 0badf00d 3

/* tb/ahb_router_tb.sv */
module ahb_router_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [7:0]  lat;
    } side_t;

    localparam int N_RAND = 40;

    logic clk;
    logic reset;
    router_pkg::ahb_req_t  imem_req;
    router_pkg::ahb_req_t  dmem_req;
    router_pkg::ahb_rsp_t  imem_rsp;
    router_pkg::ahb_rsp_t  dmem_rsp;
    router_pkg::mem_port_t inst_port;
    router_pkg::mem_port_t data_port;
    router_pkg::reg_port_t reg_port;
    logic [31:0] inst_rdata;
    logic [31:0] data_rdata;
    logic [31:0] reg_rdata;

    logic [31:0] inst_mem [4096];
    logic [31:0] data_mem [4096];
    logic [31:0] reg_mem  [8];
    logic [31:0] inst_ref [4096];
    logic [31:0] data_ref [4096];
    logic [31:0] reg_ref  [8];

    side_t imem_q [$];
    side_t dmem_q [$];
    logic [31:0] lcg_state = 32'hf1a1f926;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;

    ahb_router DUT (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Target models
    ////////////////////////////////////////
    assign inst_rdata = inst_mem[inst_port.addr];
    assign data_rdata = data_mem[data_port.addr];
    assign reg_rdata  = reg_mem[reg_port.addr];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (!inst_port.rwn && inst_port.wben[b])
                inst_mem[inst_port.addr][8*b +: 8] <= inst_port.wdata[8*b +: 8];
            if (!data_port.rwn && data_port.wben[b])
                data_mem[data_port.addr][8*b +: 8] <= data_port.wdata[8*b +: 8];
            if (!reg_port.rwn && reg_port.wben[b])
                reg_mem[reg_port.addr][8*b +: 8] <= reg_port.wdata[8*b +: 8];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run exceeded %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Lanes covered by a transfer of 1, 2 or 4 bytes at its aligned start
    function automatic logic [3:0] lanes(logic [2:0] size, logic [31:0] addr);
        int         first;
        int         count;
        logic [3:0] mask;
        count = (size == 3'd0) ? 1 : (size == 3'd1) ? 2 : 4;
        first = addr[1:0] & ~(count - 1);
        mask  = '0;
        for (int b = 0; b < 4; b++)
            mask[b] = (b >= first) && (b < first + count);
        return mask;
    endfunction

    function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] wd, logic [3:0] ben);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (ben[b])
                res[8*b +: 8] = wd[8*b +: 8];
        return res;
    endfunction

    function automatic logic [31:0] ref_read(logic [31:0] addr);
        if (addr[15])
            return reg_ref[addr[2:0]];
        return addr[14] ? data_ref[addr[13:2]] : inst_ref[addr[13:2]];
    endfunction

    task automatic ref_write(side_t s);
        logic [3:0] ben;
        ben = lanes(s.size, s.addr);
        if (s.addr[15])
            reg_ref[s.addr[2:0]] = merge(reg_ref[s.addr[2:0]], s.data, ben);
        else if (s.addr[14])
            data_ref[s.addr[13:2]] = merge(data_ref[s.addr[13:2]], s.data, ben);
        else
            inst_ref[s.addr[13:2]] = merge(inst_ref[s.addr[13:2]], s.data, ben);
    endtask

    function automatic router_pkg::ahb_req_t make_req(side_t s);
        router_pkg::ahb_req_t r;
        r.htrans = s.valid ? router_pkg::HTRANS_NONSEQ : 2'b00;
        r.haddr  = s.addr;
        r.hwrite = s.write;
        r.hsize  = router_pkg::hsize_e'(s.size);
        r.hwdata = s.data;
        return r;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic compare_rsp(string name, router_pkg::ahb_rsp_t act, router_pkg::ahb_rsp_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic compare_port(string name, router_pkg::mem_port_t act,
                                router_pkg::mem_port_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic compare_count(string name, int act, int exp);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, act, exp);
        end
    endtask

    function automatic router_pkg::mem_port_t exp_port(side_t s);
        return '{addr: s.addr[13:2], wdata: s.data, wben: lanes(s.size, s.addr), rwn: 1'b0};
    endfunction

    // Starts on a falling edge and ends one falling edge after the last hready
    task automatic run_case(side_t i, side_t d);
        bit i_done;
        bit d_done;
        bit i_strobe;
        bit d_strobe;
        int cyc;
        i_done   = !i.valid;
        d_done   = !d.valid;
        i_strobe = !(i.valid && i.write && !i.addr[15]);
        d_strobe = !(d.valid && d.write && !d.addr[15]);
        cyc      = 0;
        if (i.valid && i.write)
            ref_write(i);
        if (d.valid && d.write)
            ref_write(d);
        imem_req = make_req(i);
        dmem_req = make_req(d);
        while (!(i_done && d_done)) begin
            @(posedge clk);
            cyc++;
            @(negedge clk);
            if (!i_strobe && !(i.addr[14] ? data_port.rwn : inst_port.rwn)) begin
                compare_port("imem write port", i.addr[14] ? data_port : inst_port, exp_port(i));
                i_strobe = 1;
            end
            if (!d_strobe && !(d.addr[14] ? data_port.rwn : inst_port.rwn)) begin
                compare_port("dmem write port", d.addr[14] ? data_port : inst_port, exp_port(d));
                d_strobe = 1;
            end
            if (!i_done && imem_rsp.hready) begin
                if (!i.write)
                    compare_rsp("imem_rsp", imem_rsp, '{hready: 1'b1, hrdata: i.exp});
                if (i.lat != 0)
                    compare_count("imem latency", cyc, i.lat);
                i_done = 1;
                imem_req.htrans = 2'b00;
            end
            if (!d_done && dmem_rsp.hready) begin
                if (!d.write)
                    compare_rsp("dmem_rsp", dmem_rsp, '{hready: 1'b1, hrdata: d.exp});
                if (d.lat != 0)
                    compare_count("dmem latency", cyc, d.lat);
                d_done = 1;
                dmem_req.htrans = 2'b00;
            end
        end
        // The hready cycle is still pending, the next request follows it
        @(negedge clk);
        if (!i_strobe || !d_strobe) begin
            errors++;
            $display("Write finished without a write strobe on its RAM port at t=%0t", $time);
        end
    endtask

    task automatic read_cases();
        int fd;
        int n;
        int f [14];
        string line;
        fd = $fopen("tb/router_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Case file tb/router_cases.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h %h %h %h %d",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                if (n == 14) begin
                    imem_q.push_back('{f[0] != 0, f[1] != 0, f[2], f[3], f[4], f[5], f[6]});
                    dmem_q.push_back('{f[7] != 0, f[8] != 0, f[9], f[10], f[11], f[12],
                                       f[13]});
                end else begin
                    errors++;
                    $display("Case line has %0d fields instead of 14: %s", n, line);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        side_t       i;
        side_t       d;
        logic [31:0] r;
        clk      = 1'b0;
        reset    = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        read_cases();
        for (int a = 0; a < 4096; a++) begin
            inst_mem[a] = lcg_next();
            inst_ref[a] = inst_mem[a];
            data_mem[a] = lcg_next();
            data_ref[a] = data_mem[a];
        end
        for (int a = 0; a < 8; a++) begin
            reg_mem[a] = lcg_next();
            reg_ref[a] = reg_mem[a];
        end
        limit = (imem_q.size() + N_RAND) * 8 + 100;

        repeat (10) @(posedge clk);
        @(negedge clk);
        if (imem_rsp.hready !== 1'b0 || dmem_rsp.hready !== 1'b0) begin
            errors++;
            $display("hready is not low at the end of reset");
        end
        if (inst_port.rwn !== 1'b1 || data_port.rwn !== 1'b1 || reg_port.rwn !== 1'b1 ||
            inst_port.wben !== '0 || data_port.wben !== '0 || reg_port.wben !== '0) begin
            errors++;
            $display("A target port is not idle at the end of reset");
        end
        reset = 1'b0;
        @(negedge clk);

        foreach (imem_q[k])
            run_case(imem_q[k], dmem_q[k]);

        ////////////////////////////////////////
        // Random traffic, imem reads code only
        ////////////////////////////////////////
        for (int k = 0; k < N_RAND; k++) begin
            r = lcg_next();
            i = '{1'b1, 1'b0, 3'd2, {18'h0, r[11:0], 2'b00}, 32'h0, 32'h0, 8'd0};
            i.exp = ref_read(i.addr);
            r = lcg_next();
            d.valid = 1'b1;
            d.write = r[31];
            d.size  = r[30:29] % 3;
            d.addr  = {16'h0, r[15:0]};
            d.addr[15:14] = d.write ? (r[28] ? 2'b10 : 2'b01) : r[15:14];
            if (d.size == 3'd1)
                d.addr[0] = 1'b0;
            if (d.size == 3'd2)
                d.addr[1:0] = 2'b00;
            d.data = lcg_next();
            d.exp  = ref_read(d.addr);
            d.lat  = 8'd0;
            run_case(i, d);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb/ahb_router_chk.sv */
module ahb_router_chk (
    input logic                  clk,
    input logic                  reset,
    input router_pkg::ahb_req_t  imem_req,
    input router_pkg::ahb_req_t  dmem_req,
    input router_pkg::ahb_rsp_t  imem_rsp,
    input router_pkg::ahb_rsp_t  dmem_rsp,
    input router_pkg::mem_port_t inst_port,
    input router_pkg::mem_port_t data_port,
    input router_pkg::reg_port_t reg_port
);
    timeunit 1ns;
    timeprecision 1ps;

    // Lanes stay closed outside a write
    a_ben_idle: assert property (@(posedge clk) disable iff (reset)
        (inst_port.rwn |-> inst_port.wben == '0) and (data_port.rwn |-> data_port.wben == '0)
        and (reg_port.rwn |-> reg_port.wben == '0))
        else $error("byte enables open while rwn is high");

    // Single cycle write strobe
    a_rwn_pulse: assert property (@(posedge clk) disable iff (reset)
        (!inst_port.rwn |=> inst_port.rwn) and (!data_port.rwn |=> data_port.rwn)
        and (!reg_port.rwn |=> reg_port.rwn))
        else $error("rwn low for more than one cycle");

    a_ready_req: assert property (@(posedge clk) disable iff (reset)
        (imem_rsp.hready |-> $past(imem_req.htrans == router_pkg::HTRANS_NONSEQ))
        and (dmem_rsp.hready |-> $past(dmem_req.htrans == router_pkg::HTRANS_NONSEQ)))
        else $error("hready without a preceding request");

    a_ready_reset: assert property (@(posedge clk)
        reset |=> (!imem_rsp.hready && !dmem_rsp.hready))
        else $error("hready high during reset");

endmodule

bind ahb_router ahb_router_chk u_chk (.*);

/* rtl/ahb_router.sv */
module ahb_router (
    input  logic                            clk,
    input  logic                            reset,
    input  router_pkg::ahb_req_t            imem_req,
    input  router_pkg::ahb_req_t            dmem_req,
    output router_pkg::ahb_rsp_t            imem_rsp,
    output router_pkg::ahb_rsp_t            dmem_rsp,
    output router_pkg::mem_port_t           inst_port,
    output router_pkg::mem_port_t           data_port,
    output router_pkg::reg_port_t           reg_port,
    input  logic [router_pkg::DATA_W-1:0]   inst_rdata,
    input  logic [router_pkg::DATA_W-1:0]   data_rdata,
    input  logic [router_pkg::DATA_W-1:0]   reg_rdata
);

    router_pkg::decoded_t           imem_dec;
    router_pkg::decoded_t           dmem_dec;
    router_pkg::decoded_t           inst_sel;
    router_pkg::decoded_t           data_sel;
    router_pkg::decoded_t           reg_sel;
    logic [router_pkg::NUM_TGT-1:0] load;
    logic [router_pkg::NUM_TGT-1:0] port_busy;
    logic                           imem_grant;
    logic                           dmem_grant;
    router_pkg::target_e            imem_tgt;
    router_pkg::target_e            dmem_tgt;
    logic                           imem_busy;
    logic                           dmem_busy;

    ////////////////////////////////////////
    // Master side decode
    ////////////////////////////////////////
    ahb_addr_decode u_imem_decode (
        .req  (imem_req),
        .busy (imem_busy),
        .dec  (imem_dec)
    );

    ahb_addr_decode u_dmem_decode (
        .req  (dmem_req),
        .busy (dmem_busy),
        .dec  (dmem_dec)
    );

    target_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .imem_dec   (imem_dec),
        .dmem_dec   (dmem_dec),
        .port_busy  (port_busy),
        .inst_sel   (inst_sel),
        .data_sel   (data_sel),
        .reg_sel    (reg_sel),
        .load       (load),
        .imem_grant (imem_grant),
        .dmem_grant (dmem_grant),
        .imem_tgt   (imem_tgt),
        .dmem_tgt   (dmem_tgt)
    );

    ////////////////////////////////////////
    // Target ports
    ////////////////////////////////////////
    target_port #(.port_t(router_pkg::mem_port_t)) u_inst_port (
        .clk   (clk),
        .reset (reset),
        .load  (load[router_pkg::TGT_INST]),
        .sel   (inst_sel),
        .port  (inst_port),
        .busy  (port_busy[router_pkg::TGT_INST])
    );

    target_port #(.port_t(router_pkg::mem_port_t)) u_data_port (
        .clk   (clk),
        .reset (reset),
        .load  (load[router_pkg::TGT_DATA]),
        .sel   (data_sel),
        .port  (data_port),
        .busy  (port_busy[router_pkg::TGT_DATA])
    );

    target_port #(.port_t(router_pkg::reg_port_t)) u_reg_port (
        .clk   (clk),
        .reset (reset),
        .load  (load[router_pkg::TGT_REG]),
        .sel   (reg_sel),
        .port  (reg_port),
        .busy  (port_busy[router_pkg::TGT_REG])
    );

    response_mux u_response (
        .clk        (clk),
        .reset      (reset),
        .imem_grant (imem_grant),
        .dmem_grant (dmem_grant),
        .imem_tgt   (imem_tgt),
        .dmem_tgt   (dmem_tgt),
        .imem_write (imem_dec.write),
        .dmem_write (dmem_dec.write),
        .inst_rdata (inst_rdata),
        .data_rdata (data_rdata),
        .reg_rdata  (reg_rdata),
        .imem_busy  (imem_busy),
        .dmem_busy  (dmem_busy),
        .imem_rsp   (imem_rsp),
        .dmem_rsp   (dmem_rsp)
    );

endmodule

/* rtl/response_mux.sv */
module response_mux (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            imem_grant,
    input  logic                            dmem_grant,
    input  router_pkg::target_e             imem_tgt,
    input  router_pkg::target_e             dmem_tgt,
    input  logic                            imem_write,
    input  logic                            dmem_write,
    input  logic [router_pkg::DATA_W-1:0]   inst_rdata,
    input  logic [router_pkg::DATA_W-1:0]   data_rdata,
    input  logic [router_pkg::DATA_W-1:0]   reg_rdata,
    output logic                            imem_busy,
    output logic                            dmem_busy,
    output router_pkg::ahb_rsp_t            imem_rsp,
    output router_pkg::ahb_rsp_t            dmem_rsp
);

    logic [router_pkg::NUM_MST-1:0] grant;
    logic [router_pkg::NUM_MST-1:0] write;
    router_pkg::target_e            tgt      [router_pkg::NUM_MST];
    router_pkg::target_e            pend_tgt [router_pkg::NUM_MST];
    logic [1:0]                     cnt      [router_pkg::NUM_MST];
    logic [router_pkg::DATA_W-1:0]  hrdata   [router_pkg::NUM_MST];

    // Index 0 is imem, index 1 is dmem
    assign grant  = {dmem_grant, imem_grant};
    assign write  = {dmem_write, imem_write};
    assign tgt[0] = imem_tgt;
    assign tgt[1] = dmem_tgt;

    ////////////////////////////////////////
    // Pending access per master
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int m = 0; m < router_pkg::NUM_MST; m++) begin
            if (grant[m]) begin
                pend_tgt[m] <= tgt[m];
            end

            if (reset) begin
                cnt[m] <= '0;
            end else if (grant[m]) begin
                cnt[m] <= write[m] ? router_pkg::WR_WAIT : router_pkg::RD_WAIT;
            end else if (cnt[m] != 2'd0) begin
                cnt[m] <= cnt[m] - 2'd1;
            end
        end
    end

    // Read data follows the port address loaded at the grant edge
    always_comb begin
        for (int m = 0; m < router_pkg::NUM_MST; m++) begin
            case (pend_tgt[m])
                router_pkg::TGT_INST: hrdata[m] = inst_rdata;
                router_pkg::TGT_DATA: hrdata[m] = data_rdata;
                default:              hrdata[m] = reg_rdata;
            endcase
        end
    end

    // hready cycle still counts as pending
    assign imem_busy = (cnt[0] != 2'd0);
    assign dmem_busy = (cnt[1] != 2'd0);

    assign imem_rsp = '{hready: (cnt[0] == 2'd1), hrdata: hrdata[0]};
    assign dmem_rsp = '{hready: (cnt[1] == 2'd1), hrdata: hrdata[1]};

endmodule

/* rtl/target_port.sv */
module target_port #(
    parameter type port_t = router_pkg::mem_port_t
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  router_pkg::decoded_t sel,
    output port_t                port,
    output logic                 busy
);

    logic [router_pkg::WORD_W-1:0] addr_full;

    // Register block uses the byte address bits, RAMs the word index
    always_comb begin
        if (sel.target == router_pkg::TGT_REG) begin
            addr_full = {{(router_pkg::WORD_W - router_pkg::REG_W){1'b0}}, sel.reg_addr};
        end else begin
            addr_full = sel.word;
        end
    end

    ////////////////////////////////////////
    // Port registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            port.addr  <= addr_full[$bits(port.addr)-1:0];
            port.wdata <= sel.wdata;
        end

        if (reset) begin
            port.rwn  <= 1'b1;
            port.wben <= '0;
        end else if (load) begin
            // Reads keep the lanes closed
            port.rwn  <= ~sel.write;
            port.wben <= sel.write ? sel.wben : '0;
        end else begin
            // Write strobe lasts a single cycle
            port.rwn  <= 1'b1;
            port.wben <= '0;
        end
    end

    assign busy = ~port.rwn;

endmodule

/* rtl/target_arbiter.sv */
module target_arbiter (
    input  logic                                clk,
    input  logic                                reset,
    input  router_pkg::decoded_t                imem_dec,
    input  router_pkg::decoded_t                dmem_dec,
    input  logic [router_pkg::NUM_TGT-1:0]      port_busy,
    output router_pkg::decoded_t                inst_sel,
    output router_pkg::decoded_t                data_sel,
    output router_pkg::decoded_t                reg_sel,
    output logic [router_pkg::NUM_TGT-1:0]      load,
    output logic                                imem_grant,
    output logic                                dmem_grant,
    output router_pkg::target_e                 imem_tgt,
    output router_pkg::target_e                 dmem_tgt
);

    logic [router_pkg::NUM_TGT-1:0] imem_want;
    logic [router_pkg::NUM_TGT-1:0] dmem_want;
    logic [router_pkg::NUM_TGT-1:0] imem_win;
    logic [router_pkg::NUM_TGT-1:0] dmem_win;
    logic [router_pkg::NUM_TGT-1:0] contend;
    logic [router_pkg::NUM_TGT-1:0] favor_dmem;
    router_pkg::decoded_t           sel [router_pkg::NUM_TGT];

    ////////////////////////////////////////
    // Per-target grant
    ////////////////////////////////////////
    always_comb begin
        for (int t = 0; t < router_pkg::NUM_TGT; t++) begin
            imem_want[t] = imem_dec.valid && (imem_dec.target == router_pkg::target_e'(t));
            dmem_want[t] = dmem_dec.valid && (dmem_dec.target == router_pkg::target_e'(t));
            // A port in its write cycle takes nothing new
            contend[t]  = imem_want[t] && dmem_want[t] && !port_busy[t];
            imem_win[t] = imem_want[t] && !port_busy[t] && (!dmem_want[t] || !favor_dmem[t]);
            dmem_win[t] = dmem_want[t] && !port_busy[t] && (!imem_want[t] || favor_dmem[t]);
            load[t]     = imem_win[t] || dmem_win[t];
            sel[t]      = dmem_win[t] ? dmem_dec : imem_dec;
        end
    end

    // Favor flips only when a contended grant is actually made
    always_ff @(posedge clk) begin
        if (reset) begin
            favor_dmem <= router_pkg::FAVOR_RST;
        end else begin
            favor_dmem <= favor_dmem ^ contend;
        end
    end

    assign inst_sel = sel[router_pkg::TGT_INST];
    assign data_sel = sel[router_pkg::TGT_DATA];
    assign reg_sel  = sel[router_pkg::TGT_REG];

    // Each master asks for one target at most
    assign imem_grant = |imem_win;
    assign dmem_grant = |dmem_win;
    assign imem_tgt   = imem_dec.target;
    assign dmem_tgt   = dmem_dec.target;

endmodule

/* rtl/ahb_addr_decode.sv */
module ahb_addr_decode (
    input  router_pkg::ahb_req_t req,
    input  logic                 busy,
    output router_pkg::decoded_t dec
);

    always_comb begin
        // Masked while the previous access of this master is pending
        dec.valid = (req.htrans == router_pkg::HTRANS_NONSEQ) && !busy;

        // Bits 15:14 pick the target, 1x goes to the register block
        if (req.haddr[15]) begin
            dec.target = router_pkg::TGT_REG;
        end else if (req.haddr[14]) begin
            dec.target = router_pkg::TGT_DATA;
        end else begin
            dec.target = router_pkg::TGT_INST;
        end

        dec.word     = req.haddr[13:2];
        dec.reg_addr = req.haddr[2:0];

        // Lane enables from size and low address bits
        case (req.hsize)
            router_pkg::SIZE_BYTE: begin
                dec.wben = 4'b0001 << req.haddr[1:0];
            end
            router_pkg::SIZE_HALF: begin
                dec.wben = req.haddr[1] ? 4'b1100 : 4'b0011;
            end
            router_pkg::SIZE_WORD: begin
                dec.wben = 4'b1111;
            end
            default: begin
                dec.wben = 4'b1111;
            end
        endcase

        dec.write = req.hwrite;
        dec.wdata = req.hwdata;
    end

endmodule

/* rtl/router_pkg.sv */
package router_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int WORD_W  = 12;
    localparam int REG_W   = 3;
    localparam int BEN_W   = DATA_W / 8;
    localparam int NUM_TGT = 3;
    localparam int NUM_MST = 2;

    // htrans code that marks a new transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // Response countdown loaded at the grant edge
    localparam logic [1:0] RD_WAIT = 2'd1;
    localparam logic [1:0] WR_WAIT = 2'd2;

    // One bit per target, set means dmem is favored
    localparam logic [NUM_TGT-1:0] FAVOR_RST = 3'b110;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hsize_e;

    typedef enum logic [1:0] {
        TGT_INST = 2'b00,
        TGT_DATA = 2'b01,
        TGT_REG  = 2'b10
    } target_e;

    ////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////
    typedef struct packed {
        logic [1:0]        htrans;
        logic [ADDR_W-1:0] haddr;
        logic              hwrite;
        hsize_e            hsize;
        logic [DATA_W-1:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic              hready;
        logic [DATA_W-1:0] hrdata;
    } ahb_rsp_t;

    typedef struct packed {
        logic              valid;
        target_e           target;
        logic [WORD_W-1:0] word;
        logic [REG_W-1:0]  reg_addr;
        logic [BEN_W-1:0]  wben;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } decoded_t;

    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BEN_W-1:0]  wben;
        logic              rwn;
    } mem_port_t;

    typedef struct packed {
        logic [REG_W-1:0]  addr;
        logic [DATA_W-1:0] wdata;
        logic [BEN_W-1:0]  wben;
        logic              rwn;
    } reg_port_t;

endpackage
